//--- verilog.f
+incdir+verilog
verilog/iwdg_pkg.sv
verilog/iwdg_bus_slave.sv
verilog/iwdg_key_regs.sv
verilog/iwdg_countdown.sv
verilog/iwdg_top.sv
tb/iwdg_tb.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= iwdg_tb
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "=== FAIL ===" $(LOG); then echo "Simulation failed"; exit 1; fi
	@grep -q "=== PASS ===" $(LOG) || { echo "Simulation did not finish"; exit 1; }

lint:
	$(VERILATOR) --lint-only -Wall --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- tb/iwdg_tb.sv
`timescale 1ns/1ns
`default_nettype none

`include "iwdg_defs.svh"

module iwdg_tb
  import iwdg_pkg::*;
();

  localparam iwdg_addr_t kr_adr    = `IWDG_BASE_ADR + `IWDG_KR_OFS;
  localparam iwdg_addr_t pr_adr    = `IWDG_BASE_ADR + `IWDG_PR_OFS;
  localparam iwdg_addr_t rlr_adr   = `IWDG_BASE_ADR + `IWDG_RLR_OFS;
  localparam iwdg_addr_t st_adr    = `IWDG_BASE_ADR + `IWDG_ST_OFS;
  localparam iwdg_addr_t none_adr  = `IWDG_BASE_ADR + 32'h0000_0010;  // Just past the map
  localparam iwdg_addr_t other_adr = 32'h0200_0000;                   // Outside the window

  logic         clk_lsi;
  logic         rst_m2s;
  iwdg_addr_t   adr_m2s;
  iwdg_data_t   dat_m2s;
  logic         cyc_m2s;
  logic         stb_m2s;
  logic         we_m2s;
  iwdg_data_t   dat_s2m;
  logic         ack_s2m;
  logic         rst_iwdg;

  iwdg_data_t   m_key;                                 // Register model
  iwdg_pr_t     m_pr;
  iwdg_rlr_t    m_rlr;
  iwdg_status_t m_st;
  logic [31:0]  rng_state = 32'h4c7b;                  // Xorshift state, fixed seed
  int           error_count = 0;
  int           cycle_cnt = 0;                         // Counted on falling edges
  int           pulse_cyc[$];                          // Cycle of each rst_iwdg pulse
  logic         rst_prev = 1'b0;

  iwdg_top iwdg_top_inst (
    .clk_lsi  (clk_lsi),
    .rst_m2s  (rst_m2s),
    .adr_m2s  (adr_m2s),
    .dat_m2s  (dat_m2s),
    .cyc_m2s  (cyc_m2s),
    .stb_m2s  (stb_m2s),
    .we_m2s   (we_m2s),
    .dat_s2m  (dat_s2m),
    .ack_s2m  (ack_s2m),
    .rst_iwdg (rst_iwdg)
  );

  initial
  begin
    clk_lsi = 1'b0;
    forever #10 clk_lsi = ~clk_lsi;                    // 20 ns period
  end

  function automatic logic [31:0] next_rand();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  task automatic stop_run();
    error_count++;
    $display("=== FAIL ===");
    $fatal(1, "Simulation stopped on the first error");
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp)
    begin
      $display("Error %s got 0x%0h expected 0x%0h", name, got, exp);
      stop_run();
    end
  endtask

  // Outputs sampled mid-cycle, away from the rising edge
  always @(negedge clk_lsi)
  begin
    cycle_cnt++;
    if (!rst_m2s)
    begin
      if (rst_iwdg && rst_prev)
      begin
        $display("rst_iwdg stayed high for more than one cycle");
        stop_run();
      end
      if (rst_iwdg)
        pulse_cyc.push_back(cycle_cnt);
      if (!ack_s2m)
        check_value("dat_s2m outside ack", 32'(dat_s2m), 0);   // Bus data idles at zero
      rst_prev = rst_iwdg;
    end
  end

  task automatic bus_access(input iwdg_addr_t addr, input iwdg_data_t wdata,
                            input logic write, output iwdg_data_t rdata);
    int waited;
    @(posedge clk_lsi);
    #2;
    adr_m2s = addr;
    dat_m2s = wdata;
    we_m2s  = write;
    cyc_m2s = 1'b1;
    stb_m2s = 1'b1;
    waited  = 0;
    do
    begin
      @(posedge clk_lsi);
      #2;
      waited++;
      if (waited > 8)
      begin
        $display("No ack from the DUT within 8 cycles at address 0x%h", addr);
        stop_run();
      end
    end
    while (!ack_s2m);
    check_value("ack_s2m latency", waited, 1);         // Ack one cycle after the request
    rdata   = dat_s2m;
    cyc_m2s = 1'b0;                                    // Dropped inside the ack cycle
    stb_m2s = 1'b0;
    we_m2s  = 1'b0;
  endtask

  task automatic model_write(input iwdg_addr_t addr, input iwdg_data_t data);
    if (addr == kr_adr)
    begin
      if (data == `IWDG_KEY_RELOAD)
        m_st[1] = 1'b1;                                // Reload is a command, key unchanged
      else
        m_key = data;
    end
    else if (addr == pr_adr && m_key == `IWDG_KEY_ACCESS)
    begin
      m_pr    = (data[2:0] > `IWDG_PR_MAX) ? `IWDG_PR_MAX : data[2:0];
      m_st[0] = 1'b1;
    end
    else if (addr == rlr_adr && m_key == `IWDG_KEY_ACCESS)
      m_rlr = data[11:0];
    else if (addr == st_adr)
      m_st = m_st & ~data[1:0];                        // Write one to clear
  endtask

  function automatic iwdg_data_t model_read(input iwdg_addr_t addr);
    if (addr == kr_adr)
      return m_key;
    if (addr == pr_adr)
      return iwdg_data_t'(m_pr);
    if (addr == rlr_adr)
      return iwdg_data_t'(m_rlr);
    if (addr == st_adr)
      return iwdg_data_t'(m_st);
    return '0;                                         // Unmapped
  endfunction

  task automatic reg_write(input iwdg_addr_t addr, input iwdg_data_t data);
    iwdg_data_t rd;
    bus_access(addr, data, 1'b1, rd);
    model_write(addr, data);
  endtask

  task automatic read_check(input iwdg_addr_t addr);
    iwdg_data_t rd;
    bus_access(addr, '0, 1'b0, rd);
    check_value($sformatf("dat_s2m at 0x%h", addr), 32'(rd), 32'(model_read(addr)));
  endtask

  task automatic check_all_regs();
    read_check(kr_adr);
    read_check(pr_adr);
    read_check(rlr_adr);
    read_check(st_adr);
    read_check(none_adr);
  endtask

  task automatic wait_pulses(input int n, input int limit);
    int waited;
    waited = 0;
    while (pulse_cyc.size() < n)
    begin
      @(posedge clk_lsi);
      waited++;
      if (waited > limit)
      begin
        $display("No rst_iwdg pulse within %0d cycles", limit);
        stop_run();
      end
    end
  endtask

  task automatic idle_cycles(input int n);
    for (int i = 0; i < n; i++)
      @(posedge clk_lsi);
  endtask

  initial
  begin
    logic [31:0] r;
    int          code;
    int          rlr;
    int          div_cyc;
    int          snap;
    iwdg_addr_t  adr;
    iwdg_data_t  wd;
    rst_m2s = 1'b1;
    adr_m2s = '0;
    dat_m2s = '0;
    cyc_m2s = 1'b0;
    stb_m2s = 1'b0;
    we_m2s  = 1'b0;
    m_key   = `IWDG_KEY_IDLE;
    m_pr    = '0;
    m_rlr   = `IWDG_RLR_DEFAULT;
    m_st    = '0;
    repeat (5) @(posedge clk_lsi);
    #2;
    rst_m2s = 1'b0;

    check_all_regs();                                  // Reset values
    idle_cycles(20);
    check_value("rst_iwdg pulse count", pulse_cyc.size(), 0);

    reg_write(pr_adr, 16'h0005);                       // Locked, both dropped
    reg_write(rlr_adr, 16'h0123);
    check_all_regs();
    reg_write(kr_adr, `IWDG_KEY_ACCESS);
    reg_write(pr_adr, 16'h0007);                       // Code 7 saturates
    check_all_regs();
    repeat (6)
    begin
      r = next_rand();
      reg_write(pr_adr, r[15:0]);
      reg_write(rlr_adr, r[31:16]);
      check_all_regs();
    end

    reg_write(kr_adr, `IWDG_KEY_RELOAD);               // Sets status bit 1 only
    check_all_regs();
    reg_write(st_adr, 16'h0001);
    check_all_regs();
    reg_write(st_adr, 16'h0002);
    check_all_regs();
    reg_write(none_adr, 16'hFFFF);
    check_all_regs();

    r       = next_rand();
    code    = int'(r % 2);
    r       = next_rand();
    rlr     = int'(1 + r % 15);
    div_cyc = 4 << code;
    reg_write(pr_adr, iwdg_data_t'(code));
    reg_write(rlr_adr, iwdg_data_t'(rlr));
    pulse_cyc.delete();
    reg_write(kr_adr, `IWDG_KEY_COUNT);
    wait_pulses(3, 4 * (rlr + 1) * div_cyc);
    check_value("rst_iwdg interval", pulse_cyc[1] - pulse_cyc[0], (rlr + 1) * div_cyc);
    check_value("rst_iwdg interval", pulse_cyc[2] - pulse_cyc[1], (rlr + 1) * div_cyc);

    reg_write(kr_adr, `IWDG_KEY_RELOAD);               // Kick right after a pulse
    idle_cycles(2);
    snap = pulse_cyc.size();
    repeat ((rlr + 1) * div_cyc)                       // Kicking outlasts two timeouts
    begin
      r = next_rand();
      idle_cycles(int'(r % 2));                        // Kick gap stays under the timeout
      reg_write(kr_adr, `IWDG_KEY_RELOAD);
    end
    reg_write(kr_adr, `IWDG_KEY_IDLE);                 // Stop counting
    idle_cycles(4 * (rlr + 1) * div_cyc);
    check_value("rst_iwdg pulse count", pulse_cyc.size(), snap);
    check_all_regs();

    repeat (200)
    begin
      r = next_rand();
      case (r[2:0])
        3'd0, 3'd1: adr = kr_adr;
        3'd2:       adr = pr_adr;
        3'd3:       adr = rlr_adr;
        3'd4:       adr = st_adr;
        3'd5:       adr = none_adr;
        default:    adr = other_adr;
      endcase
      wd = r[31:16];
      if (adr == kr_adr && r[4:3] == 2'd0)
        wd = `IWDG_KEY_IDLE;
      else if (adr == kr_adr && r[4:3] == 2'd1)
        wd = `IWDG_KEY_ACCESS;
      else if (adr == kr_adr && r[4:3] == 2'd2)
        wd = `IWDG_KEY_RELOAD;
      if (r[5])
        reg_write(adr, wd);
      else
        read_check(adr);
    end
    check_all_regs();

    if (error_count == 0)
    begin
      $display("=== PASS ===");
    end
    else
    begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- verilog/iwdg_top.sv
`timescale 1ns/1ns
`default_nettype none

module iwdg_top
  import iwdg_pkg::*;
(
  input  logic       clk_lsi,                          // LSI oscillator clock
  input  logic       rst_m2s,                          // Bus reset, sync active high
  input  iwdg_addr_t adr_m2s,
  input  iwdg_data_t dat_m2s,
  input  logic       cyc_m2s,
  input  logic       stb_m2s,
  input  logic       we_m2s,
  output iwdg_data_t dat_s2m,
  output logic       ack_s2m,
  output logic       rst_iwdg                          // Watchdog reset pulse
);

  iwdg_reg_access_t reg_access;                        // Bus FSM to registers
  iwdg_data_t       rd_data;                           // Registers back to bus FSM
  iwdg_count_ctrl_t count_ctrl;                        // Registers to countdown

  iwdg_bus_slave iwdg_bus_slave_inst (
    .clk_lsi    (clk_lsi),
    .rst_m2s    (rst_m2s),
    .adr_m2s    (adr_m2s),
    .dat_m2s    (dat_m2s),
    .cyc_m2s    (cyc_m2s),
    .stb_m2s    (stb_m2s),
    .we_m2s     (we_m2s),
    .rd_data    (rd_data),
    .dat_s2m    (dat_s2m),
    .ack_s2m    (ack_s2m),
    .reg_access (reg_access)
  );

  iwdg_key_regs iwdg_key_regs_inst (
    .clk_lsi    (clk_lsi),
    .rst_m2s    (rst_m2s),
    .reg_access (reg_access),
    .rd_data    (rd_data),
    .count_ctrl (count_ctrl)
  );

  iwdg_countdown iwdg_countdown_inst (
    .clk_lsi    (clk_lsi),
    .rst_m2s    (rst_m2s),
    .count_ctrl (count_ctrl),
    .rst_iwdg   (rst_iwdg)
  );

endmodule

`default_nettype wire

//--- verilog/iwdg_countdown.sv
`timescale 1ns/1ns
`default_nettype none

module iwdg_countdown
  import iwdg_pkg::*;
(
  input  logic             clk_lsi,
  input  logic             rst_m2s,
  input  iwdg_count_ctrl_t count_ctrl,
  output logic             rst_iwdg
);

  logic [7:0] pre_q;                                   // Prescaler, counts down to zero
  logic [7:0] pre_load;                                // Divider minus one
  iwdg_rlr_t  cnt_q;                                   // Watchdog down-counter
  logic       enable_q;                                // Enable one cycle ago
  logic       restart;
  logic       tick;

  // 4 << code, the 256 case wraps to zero and then to 255
  assign pre_load = 8'((9'd4 << count_ctrl.prescale) - 9'd1);

  assign restart = count_ctrl.reload || (count_ctrl.enable && !enable_q); // Reload or start
  assign tick    = count_ctrl.enable && !restart && (pre_q == '0); // Every divider cycles

  always_ff @(posedge clk_lsi)
  begin
    if (rst_m2s)
    begin
      pre_q    <= '0;
      cnt_q    <= '0;
      enable_q <= 1'b0;
    end
    else
    begin
      enable_q <= count_ctrl.enable;
      if (restart)
      begin
        pre_q <= pre_load;                             // Fresh prescaler period
        cnt_q <= count_ctrl.reload_value;
      end
      else if (count_ctrl.enable)
      begin
        if (tick)
        begin
          pre_q <= pre_load;
          if (cnt_q == '0)
            cnt_q <= count_ctrl.reload_value;          // Expired, start over
          else
            cnt_q <= cnt_q - 1'b1;
        end
        else
        begin
          pre_q <= pre_q - 1'b1;
        end
      end
      // Disabled, both counters hold
    end
  end

  assign rst_iwdg = tick && (cnt_q == '0);             // One cycle, decoded from flops

  // Stopping the key must also stop any reset
  a_rst_enabled: assert property (@(posedge clk_lsi) disable iff (rst_m2s)
    rst_iwdg |-> count_ctrl.enable);

endmodule

`default_nettype wire

//--- verilog/iwdg_key_regs.sv
`timescale 1ns/1ns
`default_nettype none

`include "iwdg_defs.svh"

module iwdg_key_regs
  import iwdg_pkg::*;
(
  input  logic             clk_lsi,
  input  logic             rst_m2s,
  input  iwdg_reg_access_t reg_access,
  output iwdg_data_t       rd_data,
  output iwdg_count_ctrl_t count_ctrl
);

  iwdg_data_t   key_q;                                 // Last stored key word
  iwdg_pr_t     pr_q;                                  // Prescale code, 0 to 6
  iwdg_rlr_t    rlr_q;                                 // Reload value
  iwdg_status_t st_q;                                  // Sticky status bits
  logic         reload_q;                              // Reload command pulse
  logic         wr_en;
  logic         unlocked;
  iwdg_pr_t     pr_wr;
  iwdg_pr_t     pr_clamp;

  assign wr_en    = reg_access.valid && reg_access.write;  // Write in the ack cycle
  assign unlocked = (key_q == `IWDG_KEY_ACCESS);           // PR and RLR open
  assign pr_wr    = reg_access.wdata[`IWDG_PR_W-1:0];      // Code field of the word
  assign pr_clamp = (pr_wr > `IWDG_PR_MAX) ? `IWDG_PR_MAX : pr_wr; // Code 7 saturates

  always_ff @(posedge clk_lsi)
  begin
    if (rst_m2s)
    begin
      key_q    <= `IWDG_KEY_IDLE;
      pr_q     <= '0;                                  // Divide by 4
      rlr_q    <= `IWDG_RLR_DEFAULT;
      st_q     <= '0;
      reload_q <= 1'b0;
    end
    else
    begin
      reload_q <= 1'b0;                                // Pulse lasts one cycle
      if (wr_en)
      begin
        case (reg_access.sel)
          sel_kr:
          begin
            if (reg_access.wdata == `IWDG_KEY_RELOAD)
            begin
              reload_q <= 1'b1;                        // Key itself stays as it was
              st_q[1]  <= 1'b1;
            end
            else
            begin
              key_q <= reg_access.wdata;
            end
          end
          sel_pr:
          begin
            if (unlocked)
            begin
              pr_q    <= pr_clamp;
              st_q[0] <= 1'b1;                         // Flag the accepted update
            end
          end
          sel_rlr:
          begin
            if (unlocked)
            begin
              rlr_q <= reg_access.wdata[`IWDG_RLR_W-1:0];
            end
          end
          sel_st:  st_q <= st_q & ~reg_access.wdata[`IWDG_ST_W-1:0]; // Write one to clear
          default: ;                                   // Unmapped write dropped
        endcase
      end
    end
  end

  // Read mux, values before any write in the same ack cycle
  always_comb
  begin
    case (reg_access.sel)
      sel_kr:  rd_data = key_q;
      sel_pr:  rd_data = iwdg_data_t'(pr_q);
      sel_rlr: rd_data = iwdg_data_t'(rlr_q);
      sel_st:  rd_data = iwdg_data_t'(st_q);
      default: rd_data = '0;                           // Unmapped reads as zero
    endcase
  end

  assign count_ctrl.enable       = (key_q == `IWDG_KEY_COUNT);  // Level while counting
  assign count_ctrl.reload       = reload_q;
  assign count_ctrl.prescale     = pr_q;
  assign count_ctrl.reload_value = rlr_q;

  // Countdown shift amount must stay inside the 8-bit prescaler
  a_pr_range: assert property (@(posedge clk_lsi) disable iff (rst_m2s)
    pr_q <= `IWDG_PR_MAX);

endmodule

`default_nettype wire

//--- verilog/iwdg_bus_slave.sv
`timescale 1ns/1ns
`default_nettype none

`include "iwdg_defs.svh"

module iwdg_bus_slave
  import iwdg_pkg::*;
(
  input  logic             clk_lsi,
  input  logic             rst_m2s,
  input  iwdg_addr_t       adr_m2s,
  input  iwdg_data_t       dat_m2s,
  input  logic             cyc_m2s,
  input  logic             stb_m2s,
  input  logic             we_m2s,
  input  iwdg_data_t       rd_data,                    // Read value from the register block
  output iwdg_data_t       dat_s2m,
  output logic             ack_s2m,
  output iwdg_reg_access_t reg_access
);

  bus_state_e    state_q;                              // Bus FSM state
  bus_state_e    state_d;
  iwdg_reg_sel_e sel_dec;                              // Select decoded from adr_m2s
  iwdg_reg_sel_e sel_q;                                // Select held for the ack cycle
  logic          we_q;                                 // Captured direction
  iwdg_data_t    wdata_q;                              // Captured write data
  logic          req;

  assign req = cyc_m2s && stb_m2s;                     // Valid bus cycle

  // Full 32-bit compare, anything off the four words falls to sel_none
  always_comb
  begin
    case (adr_m2s)
      `IWDG_BASE_ADR + `IWDG_KR_OFS:  sel_dec = sel_kr;
      `IWDG_BASE_ADR + `IWDG_PR_OFS:  sel_dec = sel_pr;
      `IWDG_BASE_ADR + `IWDG_RLR_OFS: sel_dec = sel_rlr;
      `IWDG_BASE_ADR + `IWDG_ST_OFS:  sel_dec = sel_st;
      default:                        sel_dec = sel_none;
    endcase
  end

  always_comb
  begin
    state_d = state_q;
    case (state_q)
      st_idle:   if (req) state_d = st_access;       // Request seen, ack next cycle
      st_access: state_d = st_idle;                  // Always a single ack cycle
      default:   state_d = st_idle;
    endcase
  end

  always_ff @(posedge clk_lsi)
  begin
    if (rst_m2s)
    begin
      state_q <= st_idle;
    end
    else
    begin
      state_q <= state_d;
    end
  end

  // Request payload, only sampled when leaving idle
  always_ff @(posedge clk_lsi)
  begin
    if (state_q == st_idle && req)
    begin
      we_q    <= we_m2s;
      sel_q   <= sel_dec;
      wdata_q <= dat_m2s;
    end
  end

  assign ack_s2m          = (state_q == st_access); // One-cycle ack
  assign dat_s2m          = (ack_s2m && !we_q) ? rd_data : '0; // Zero outside read ack
  assign reg_access.valid = ack_s2m;                 // Register block acts on the ack cycle
  assign reg_access.write = we_q;
  assign reg_access.sel   = sel_q;
  assign reg_access.wdata = wdata_q;

  // Master drops stb after ack, so acks never come back to back
  a_ack_single: assert property (@(posedge clk_lsi) disable iff (rst_m2s)
    ack_s2m |=> !ack_s2m);

endmodule

`default_nettype wire

//--- verilog/iwdg_pkg.sv
`default_nettype none

package iwdg_pkg;

  `include "iwdg_defs.svh"

  typedef logic [31:0]                 iwdg_addr_t;    // Bus byte address
  typedef logic [`IWDG_DATA_W-1:0]     iwdg_data_t;    // Bus word, also the key
  typedef logic [`IWDG_PR_W-1:0]       iwdg_pr_t;      // Divider is 4 << code
  typedef logic [`IWDG_RLR_W-1:0]      iwdg_rlr_t;     // Reload and count value
  typedef logic [`IWDG_ST_W-1:0]       iwdg_status_t;  // Bit 0 PR update, bit 1 reload

  typedef enum logic [2:0] {
    sel_kr,                                            // Key register
    sel_pr,                                            // Prescale register
    sel_rlr,                                           // Reload register
    sel_st,                                            // Status register
    sel_none                                           // Unmapped address
  } iwdg_reg_sel_e;

  typedef enum logic [1:0] {
    st_idle,                                           // Waiting for cyc and stb
    st_access                                          // Ack cycle
  } bus_state_e;

  typedef struct packed {
    logic          valid;                              // High for the ack cycle only
    logic          write;                              // Write when set, else read
    iwdg_reg_sel_e sel;                                // Decoded register
    iwdg_data_t    wdata;                              // Captured write data
  } iwdg_reg_access_t;

  typedef struct packed {
    logic      enable;                                 // Key holds the count key
    logic      reload;                                 // One-cycle reload command
    iwdg_pr_t  prescale;                               // Current prescale code
    iwdg_rlr_t reload_value;                           // Value loaded into the counter
  } iwdg_count_ctrl_t;

endpackage

`default_nettype wire

//--- verilog/iwdg_defs.svh
`ifndef IWDG_DEFS_SVH
`define IWDG_DEFS_SVH

// Register map, seen from the bus
`define IWDG_BASE_ADR      32'h0100_0000         // Base of the watchdog window
`define IWDG_KR_OFS        32'h0000_0000         // Key register
`define IWDG_PR_OFS        32'h0000_0004         // Prescale register
`define IWDG_RLR_OFS       32'h0000_0008         // Reload register
`define IWDG_ST_OFS        32'h0000_000C         // Status register

// Key words written to the key register
`define IWDG_KEY_IDLE      16'h0000              // Stops the countdown
`define IWDG_KEY_COUNT     16'hCCCC              // Starts the countdown
`define IWDG_KEY_RELOAD    16'hAAAA              // One-shot reload, not stored
`define IWDG_KEY_ACCESS    16'h5555              // Unlocks PR and RLR writes

// Field widths
`define IWDG_DATA_W        16                    // Bus data and key
`define IWDG_PR_W          3                     // Prescale code
`define IWDG_RLR_W         12                    // Reload and counter value
`define IWDG_ST_W          2                     // Status bits

// Reset and limit values
`define IWDG_RLR_DEFAULT   12'hFFF               // Longest timeout after reset
`define IWDG_PR_MAX        3'd6                  // Code 6 divides by 256

`endif
